/* hw/ooo_pkg.sv */
/*
  Shared sizes and types for the out-of-order RV32I back end.
  Every instruction writes rd. A write to x0 is renamed but never mapped.
  Only add and low-word multiply exist, with no subtract and no stores.
*/
package ooo_pkg;

  // ==========================================================
  // Sizes
  // ==========================================================
  localparam int XLEN       = 32;
  localparam int ARCH_REGS  = 32;
  localparam int PHYS_REGS  = 48;
  localparam int FREE_REGS  = PHYS_REGS - ARCH_REGS;
  localparam int ROB_DEPTH  = 8;
  localparam int RS_DEPTH   = 2;
  localparam int MUL_STAGES = 3;
  localparam int NUM_UNITS  = 2;

  typedef logic [XLEN-1:0]               word_t;
  typedef logic [$clog2(ARCH_REGS)-1:0]  arch_idx_t;
  typedef logic [$clog2(PHYS_REGS)-1:0]  phys_tag_t;
  typedef logic [$clog2(ROB_DEPTH)-1:0]  rob_idx_t;

  // Opcode and cluster index at once
  typedef enum logic {
    UNIT_ADD = 1'b0,
    UNIT_MUL = 1'b1
  } unit_e;

  // ==========================================================
  // Bundles
  // ==========================================================
  typedef struct packed {
    unit_e     unit;
    arch_idx_t rs1;
    logic      rs2_vld;   // Low selects imm as second source
    arch_idx_t rs2;
    arch_idx_t rd;
    word_t     imm;
  } dec_instr_t;

  typedef struct packed {
    logic      src1_rdy;
    phys_tag_t src1_tag;
    word_t     src1_val;
    logic      src2_rdy;
    phys_tag_t src2_tag;
    word_t     src2_val;
    phys_tag_t dst_tag;
    rob_idx_t  rob_idx;
  } rs_entry_t;

  typedef struct packed {
    logic      valid;
    phys_tag_t tag;
    rob_idx_t  rob_idx;
    word_t     data;
  } wb_bus_t;

  typedef struct packed {
    logic      valid;
    arch_idx_t rd;
    word_t     value;
  } retire_t;

endpackage

/* hw/dispatch_stage.sv */
/*
  Accepts one decoded instruction per four-phase req/ack cycle.
  i_dec_instr must stay stable while req is high and ack is low.
*/
`timescale 1ns/1ps

module dispatch_stage
  import ooo_pkg::*;
(
  input  logic                 clk,
  input  logic                 i_reset,
  input  logic                 i_dec_req,
  input  dec_instr_t           i_dec_instr,
  output logic                 o_dec_ack,
  input  logic                 i_src1_rdy,
  input  phys_tag_t            i_src1_tag,
  input  word_t                i_src1_val,
  input  logic                 i_src2_rdy,
  input  phys_tag_t            i_src2_tag,
  input  word_t                i_src2_val,
  input  phys_tag_t            i_new_tag,
  input  logic                 i_free_empty,
  input  logic [NUM_UNITS-1:0] i_rs_full,
  input  logic                 i_rob_full,
  input  rob_idx_t             i_rob_idx,
  output arch_idx_t            o_ren_rs1,
  output arch_idx_t            o_ren_rs2,
  output logic                 o_ren_rs2_vld,
  output arch_idx_t            o_ren_rd,
  output logic                 o_commit,
  output logic [NUM_UNITS-1:0] o_rs_push,
  output rs_entry_t            o_entry
);

  typedef enum logic {
    ST_IDLE,
    ST_ACKED
  } hs_state_e;

  hs_state_e state_q;
  logic      stall;

  assign stall     = i_rs_full[i_dec_instr.unit] | i_rob_full | i_free_empty;
  assign o_commit  = (state_q == ST_IDLE) & i_dec_req & ~stall;
  assign o_rs_push = o_commit ? (NUM_UNITS'(1) << i_dec_instr.unit) : '0;
  assign o_dec_ack = (state_q == ST_ACKED);

  assign o_ren_rs1     = i_dec_instr.rs1;
  assign o_ren_rs2     = i_dec_instr.rs2;
  assign o_ren_rs2_vld = i_dec_instr.rs2_vld;
  assign o_ren_rd      = i_dec_instr.rd;

  always_comb begin
    o_entry.src1_rdy = i_src1_rdy;
    o_entry.src1_tag = i_src1_tag;
    o_entry.src1_val = i_src1_val;
    o_entry.src2_rdy = i_src2_rdy;
    o_entry.src2_tag = i_src2_tag;
    o_entry.src2_val = i_src2_val;
    // I-type: the immediate is an operand that is ready at once
    if (!i_dec_instr.rs2_vld) begin
      o_entry.src2_rdy = 1'b1;
      o_entry.src2_val = i_dec_instr.imm;
    end
    o_entry.dst_tag = i_new_tag;
    o_entry.rob_idx = i_rob_idx;
  end

  // Ack rises with the accept edge and falls once req has dropped
  always_ff @(posedge clk) begin
    if (i_reset) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE:  if (o_commit) state_q <= ST_ACKED;
        ST_ACKED: if (!i_dec_req) state_q <= ST_IDLE;
        default:  state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

/* hw/rename_regfile.sv */
/*
  Map table, physical register file with ready bits, and free list.
  Reads are combinational with same-cycle write-back forwarding.
  The caller must not commit while o_free_empty is high. x0 keeps tag 0.
*/
`timescale 1ns/1ps

module rename_regfile
  import ooo_pkg::*;
(
  input  logic      clk,
  input  logic      i_reset,
  input  arch_idx_t i_ren_rs1,
  input  arch_idx_t i_ren_rs2,
  input  logic      i_ren_rs2_vld,
  input  arch_idx_t i_ren_rd,
  input  logic      i_commit,
  input  wb_bus_t   i_wb,
  input  logic      i_free_vld,
  input  phys_tag_t i_free_tag,
  output logic      o_src1_rdy,
  output phys_tag_t o_src1_tag,
  output word_t     o_src1_val,
  output logic      o_src2_rdy,
  output phys_tag_t o_src2_tag,
  output word_t     o_src2_val,
  output phys_tag_t o_new_tag,
  output phys_tag_t o_old_tag,
  output logic      o_free_empty
);

  phys_tag_t            map_q  [ARCH_REGS];
  word_t                prf_val[PHYS_REGS];
  logic [PHYS_REGS-1:0] prf_rdy;

  phys_tag_t                      free_q[FREE_REGS];
  logic [$clog2(FREE_REGS)-1:0]   free_head, free_tail;
  logic [$clog2(FREE_REGS+1)-1:0] free_cnt;

  // Ready bit and value of a tag, with the write-back bus in front
  function automatic logic [XLEN:0] read_src(input phys_tag_t tag);
    if (i_wb.valid && i_wb.tag == tag) begin
      return {1'b1, i_wb.data};
    end
    return {prf_rdy[tag], prf_val[tag]};
  endfunction

  // Tag 0 is never allocated, so it always reads ready with zero
  assign o_src1_tag = map_q[i_ren_rs1];
  assign o_src2_tag = i_ren_rs2_vld ? map_q[i_ren_rs2] : '0;
  assign {o_src1_rdy, o_src1_val} = read_src(o_src1_tag);
  assign {o_src2_rdy, o_src2_val} = read_src(o_src2_tag);

  assign o_new_tag    = free_q[free_head];
  assign o_old_tag    = map_q[i_ren_rd];
  assign o_free_empty = (free_cnt == '0);

  always_ff @(posedge clk) begin
    if (i_reset) begin
      for (int i = 0; i < ARCH_REGS; i++) begin
        map_q[i] <= phys_tag_t'(i);
      end
      for (int i = 0; i < PHYS_REGS; i++) begin
        prf_val[i] <= '0;
      end
      for (int i = 0; i < FREE_REGS; i++) begin
        free_q[i] <= phys_tag_t'(ARCH_REGS + i);
      end
      prf_rdy   <= '1;
      free_head <= '0;
      free_tail <= '0;
      free_cnt  <= FREE_REGS[$clog2(FREE_REGS+1)-1:0];
    end else begin
      if (i_commit) begin
        if (i_ren_rd != '0) begin
          map_q[i_ren_rd] <= o_new_tag;
        end
        prf_rdy[o_new_tag] <= 1'b0;
        free_head          <= free_head + 1'b1;
      end
      if (i_wb.valid) begin
        prf_rdy[i_wb.tag] <= 1'b1;
        prf_val[i_wb.tag] <= i_wb.data;
      end
      if (i_free_vld) begin
        free_q[free_tail] <= i_free_tag;
        free_tail         <= free_tail + 1'b1;
      end
      if (i_commit && !i_free_vld) begin
        free_cnt <= free_cnt - 1'b1;
      end else if (!i_commit && i_free_vld) begin
        free_cnt <= free_cnt + 1'b1;
      end
    end
  end

endmodule

/* hw/exec_cluster.sv */
/*
  Reservation station plus one execution pipeline.
  UNIT_ADD gives one stage, UNIT_MUL three stages with the low product word.
  An ungranted result at the pipeline output freezes the whole pipeline.
*/
`timescale 1ns/1ps

module exec_cluster
  import ooo_pkg::*;
#(
  parameter unit_e PU_KIND = UNIT_ADD
) (
  input  logic      clk,
  input  logic      i_reset,
  input  logic      i_push,
  input  rs_entry_t i_entry,
  input  wb_bus_t   i_wb,
  input  logic      i_grant,
  output logic      o_full,
  output wb_bus_t   o_result
);

  localparam int LAT = (PU_KIND == UNIT_MUL) ? MUL_STAGES : 1;

  // Slot 0 holds the oldest entry, the slots stay packed
  rs_entry_t           rs_q[RS_DEPTH];
  rs_entry_t           rs_d[RS_DEPTH];
  logic [RS_DEPTH-1:0] rs_vld_q, rs_vld_d;

  wb_bus_t pipe_q[LAT];
  logic    advance, issue;
  int      issue_idx;
  word_t   op_res;

  assign advance  = ~(pipe_q[LAT-1].valid & ~i_grant);
  assign o_full   = &rs_vld_q;
  assign o_result = pipe_q[LAT-1];

  // Oldest entry whose operands were ready at the last edge
  always_comb begin
    issue     = 1'b0;
    issue_idx = 0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (rs_vld_q[i] && rs_q[i].src1_rdy && rs_q[i].src2_rdy) begin
        issue     = advance;
        issue_idx = i;
      end
    end
  end

  assign op_res = (PU_KIND == UNIT_MUL) ? rs_q[issue_idx].src1_val * rs_q[issue_idx].src2_val
                                        : rs_q[issue_idx].src1_val + rs_q[issue_idx].src2_val;

  always_comb begin
    logic placed;
    placed   = 1'b0;
    rs_d     = rs_q;
    rs_vld_d = rs_vld_q;
    // Wakeup from the write-back bus
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (i_wb.valid && !rs_d[i].src1_rdy && rs_d[i].src1_tag == i_wb.tag) begin
        rs_d[i].src1_rdy = 1'b1;
        rs_d[i].src1_val = i_wb.data;
      end
      if (i_wb.valid && !rs_d[i].src2_rdy && rs_d[i].src2_tag == i_wb.tag) begin
        rs_d[i].src2_rdy = 1'b1;
        rs_d[i].src2_val = i_wb.data;
      end
    end
    // Close the gap left by the issued entry
    if (issue) begin
      for (int i = 0; i < RS_DEPTH - 1; i++) begin
        if (i >= issue_idx) begin
          rs_d[i]     = rs_d[i+1];
          rs_vld_d[i] = rs_vld_d[i+1];
        end
      end
      rs_vld_d[RS_DEPTH-1] = 1'b0;
    end
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (i_push && !placed && !rs_vld_d[i]) begin
        rs_d[i]     = i_entry;
        rs_vld_d[i] = 1'b1;
        placed      = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      rs_vld_q <= '0;
    end else begin
      rs_vld_q <= rs_vld_d;
    end
    rs_q <= rs_d;
  end

  // Result is formed at issue, the later stages only carry it
  always_ff @(posedge clk) begin
    if (i_reset) begin
      for (int i = 0; i < LAT; i++) begin
        pipe_q[i].valid <= 1'b0;
      end
    end else if (advance) begin
      pipe_q[0].valid   <= issue;
      pipe_q[0].tag     <= rs_q[issue_idx].dst_tag;
      pipe_q[0].rob_idx <= rs_q[issue_idx].rob_idx;
      pipe_q[0].data    <= op_res;
      for (int i = 1; i < LAT; i++) begin
        pipe_q[i] <= pipe_q[i-1];
      end
    end
  end

endmodule

/* hw/writeback_arbiter.sv */
/*
  Round-robin choice of one unit result per cycle. The grant is combinational.
  Priority moves past the granted unit after every grant.
*/
`timescale 1ns/1ps

module writeback_arbiter
  import ooo_pkg::*;
(
  input  logic                 clk,
  input  logic                 i_reset,
  input  wb_bus_t              i_result[NUM_UNITS],
  output logic [NUM_UNITS-1:0] o_grant,
  output wb_bus_t              o_wb
);

  localparam int PW = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1;

  logic [PW-1:0] prio_q, win;
  logic          found;

  always_comb begin
    int idx;
    o_grant = '0;
    o_wb    = '0;
    found   = 1'b0;
    win     = prio_q;
    // Search from the unit holding priority
    for (int k = 0; k < NUM_UNITS; k++) begin
      idx = (int'(prio_q) + k) % NUM_UNITS;
      if (!found && i_result[idx].valid) begin
        found = 1'b1;
        win   = PW'(idx);
      end
    end
    if (found) begin
      o_grant[win] = 1'b1;
      o_wb         = i_result[win];
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      prio_q <= '0;
    end else if (found) begin
      prio_q <= PW'((int'(win) + 1) % NUM_UNITS);
    end
  end

endmodule

/* hw/reorder_buffer.sv */
/*
  In-order retirement. The head retires one edge after its write-back lands.
  A write to x0 frees its own new tag and retires with value zero.
*/
`timescale 1ns/1ps

module reorder_buffer
  import ooo_pkg::*;
(
  input  logic      clk,
  input  logic      i_reset,
  input  logic      i_push,
  input  arch_idx_t i_rd,
  input  phys_tag_t i_new_tag,
  input  phys_tag_t i_old_tag,
  input  wb_bus_t   i_wb,
  output rob_idx_t  o_rob_idx,
  output logic      o_full,
  output logic      o_free_vld,
  output phys_tag_t o_free_tag,
  output retire_t   o_retire
);

  arch_idx_t             slot_rd  [ROB_DEPTH];
  phys_tag_t             slot_free[ROB_DEPTH];
  word_t                 slot_val [ROB_DEPTH];
  logic [ROB_DEPTH-1:0]  slot_done;

  rob_idx_t                       head_q, tail_q;
  logic [$clog2(ROB_DEPTH+1)-1:0] cnt_q;
  logic                           retire;

  assign retire     = (cnt_q != '0) && slot_done[head_q];
  assign o_rob_idx  = tail_q;
  assign o_full     = (cnt_q == ROB_DEPTH);
  assign o_free_vld = retire;
  assign o_free_tag = slot_free[head_q];

  assign o_retire.valid = retire;
  assign o_retire.rd    = slot_rd[head_q];
  assign o_retire.value = (slot_rd[head_q] == '0) ? '0 : slot_val[head_q];

  // ==========================================================
  // Pointers and completion bits
  // ==========================================================
  always_ff @(posedge clk) begin
    if (i_reset) begin
      head_q    <= '0;
      tail_q    <= '0;
      cnt_q     <= '0;
      slot_done <= '0;
    end else begin
      if (i_push) begin
        slot_done[tail_q] <= 1'b0;
        tail_q            <= tail_q + 1'b1;
      end
      if (i_wb.valid) begin
        slot_done[i_wb.rob_idx] <= 1'b1;
      end
      if (retire) begin
        head_q <= head_q + 1'b1;
      end
      if (i_push && !retire) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!i_push && retire) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Slot payload
  always_ff @(posedge clk) begin
    if (i_push) begin
      slot_rd[tail_q]   <= i_rd;
      slot_free[tail_q] <= (i_rd == '0) ? i_new_tag : i_old_tag;
    end
    if (i_wb.valid) begin
      slot_val[i_wb.rob_idx] <= i_wb.data;
    end
  end

endmodule

/* hw/ooo_core.sv */
/*
  Back end top level. One instruction is accepted per four-phase handshake.
  o_retire has no back-pressure and reports at most one retirement per cycle.
*/
`timescale 1ns/1ps

module ooo_core
  import ooo_pkg::*;
(
  input  logic       clk,
  input  logic       i_reset,
  input  logic       i_dec_req,
  input  dec_instr_t i_dec_instr,
  output logic       o_dec_ack,
  output retire_t    o_retire
);

  // Dispatch to rename
  arch_idx_t ren_rs1, ren_rs2, ren_rd;
  logic      ren_rs2_vld, commit;

  // Rename answers
  logic      src1_rdy, src2_rdy, free_empty;
  phys_tag_t src1_tag, src2_tag, new_tag, old_tag;
  word_t     src1_val, src2_val;

  // Stations, write-back and ROB
  logic [NUM_UNITS-1:0] rs_push, rs_full, wb_grant;
  rs_entry_t entry;
  wb_bus_t   unit_result [NUM_UNITS];
  wb_bus_t   wb;
  rob_idx_t  rob_idx;
  logic      rob_full, free_vld;
  phys_tag_t free_tag;

  dispatch_stage dispatch_i (
    .clk, .i_reset, .i_dec_req, .i_dec_instr, .o_dec_ack,
    .i_src1_rdy(src1_rdy), .i_src1_tag(src1_tag), .i_src1_val(src1_val),
    .i_src2_rdy(src2_rdy), .i_src2_tag(src2_tag), .i_src2_val(src2_val),
    .i_new_tag(new_tag), .i_free_empty(free_empty),
    .i_rs_full(rs_full), .i_rob_full(rob_full), .i_rob_idx(rob_idx),
    .o_ren_rs1(ren_rs1), .o_ren_rs2(ren_rs2), .o_ren_rs2_vld(ren_rs2_vld),
    .o_ren_rd(ren_rd), .o_commit(commit), .o_rs_push(rs_push), .o_entry(entry)
  );

  rename_regfile rename_i (
    .clk, .i_reset,
    .i_ren_rs1(ren_rs1), .i_ren_rs2(ren_rs2), .i_ren_rs2_vld(ren_rs2_vld),
    .i_ren_rd(ren_rd), .i_commit(commit), .i_wb(wb),
    .i_free_vld(free_vld), .i_free_tag(free_tag),
    .o_src1_rdy(src1_rdy), .o_src1_tag(src1_tag), .o_src1_val(src1_val),
    .o_src2_rdy(src2_rdy), .o_src2_tag(src2_tag), .o_src2_val(src2_val),
    .o_new_tag(new_tag), .o_old_tag(old_tag), .o_free_empty(free_empty)
  );

  // ==========================================================
  // Execution clusters, indexed by their unit code
  // ==========================================================
  exec_cluster #(.PU_KIND(UNIT_ADD)) add_cluster_i (
    .clk, .i_reset, .i_push(rs_push[UNIT_ADD]), .i_entry(entry), .i_wb(wb),
    .i_grant(wb_grant[UNIT_ADD]), .o_full(rs_full[UNIT_ADD]),
    .o_result(unit_result[UNIT_ADD])
  );

  exec_cluster #(.PU_KIND(UNIT_MUL)) mul_cluster_i (
    .clk, .i_reset, .i_push(rs_push[UNIT_MUL]), .i_entry(entry), .i_wb(wb),
    .i_grant(wb_grant[UNIT_MUL]), .o_full(rs_full[UNIT_MUL]),
    .o_result(unit_result[UNIT_MUL])
  );

  writeback_arbiter wb_arbiter_i (
    .clk, .i_reset, .i_result(unit_result), .o_grant(wb_grant), .o_wb(wb)
  );

  reorder_buffer rob_i (
    .clk, .i_reset, .i_push(commit), .i_rd(ren_rd), .i_new_tag(new_tag),
    .i_old_tag(old_tag), .i_wb(wb), .o_rob_idx(rob_idx), .o_full(rob_full),
    .o_free_vld(free_vld), .o_free_tag(free_tag), .o_retire
  );

endmodule

/* test/tb_ooo_model.svh */
/*
  Architectural reference model for the ooo_core testbench.
  The model executes in dispatch order, and each instruction queues its expected retirement.
  It is included inside the testbench module and uses the ooo_pkg types.
*/
`ifndef TB_OOO_MODEL_SVH
`define TB_OOO_MODEL_SVH

word_t   arch_reg[ARCH_REGS];
retire_t exp_q[$];

function automatic void clear_model();
  for (int i = 0; i < ARCH_REGS; i++) begin
    arch_reg[i] = '0;
  end
  exp_q.delete();
endfunction

// Executes one instruction in program order and queues its retirement
function automatic void model_dispatch(input dec_instr_t ins);
  word_t   a;
  word_t   b;
  word_t   r;
  retire_t exp;
  a = arch_reg[ins.rs1];
  b = ins.rs2_vld ? arch_reg[ins.rs2] : ins.imm;
  if (ins.unit == UNIT_MUL) begin
    r = a * b;
  end else begin
    r = a + b;
  end
  // x0 stays zero
  if (ins.rd == '0) begin
    r = '0;
  end else begin
    arch_reg[ins.rd] = r;
  end
  exp.valid = 1'b1;
  exp.rd    = ins.rd;
  exp.value = r;
  exp_q.push_back(exp);
endfunction

function automatic dec_instr_t make_instr(input unit_e unit, input int rd, input int rs1,
                                          input logic rs2_vld, input int rs2, input word_t imm);
  dec_instr_t ins;
  ins.unit    = unit;
  ins.rd      = arch_idx_t'(rd);
  ins.rs1     = arch_idx_t'(rs1);
  ins.rs2_vld = rs2_vld;
  ins.rs2     = arch_idx_t'(rs2);
  ins.imm     = imm;
  return ins;
endfunction

function automatic dec_instr_t addi_instr(input int rd, input int rs1, input word_t imm);
  return make_instr(UNIT_ADD, rd, rs1, 1'b0, 0, imm);
endfunction

function automatic dec_instr_t add_instr(input int rd, input int rs1, input int rs2);
  return make_instr(UNIT_ADD, rd, rs1, 1'b1, rs2, '0);
endfunction

function automatic dec_instr_t mul_instr(input int rd, input int rs1, input int rs2);
  return make_instr(UNIT_MUL, rd, rs1, 1'b1, rs2, '0);
endfunction

// Sources and destinations from x0..x4
function automatic dec_instr_t random_instr();
  unit_e unit;
  unit = ($urandom % 2 == 0) ? UNIT_ADD : UNIT_MUL;
  return make_instr(unit, int'($urandom % 5), int'($urandom % 5),
                    ($urandom % 3) != 0, int'($urandom % 5), $urandom);
endfunction

`endif

/* test/tb_ooo_core.sv */
/*
  Testbench for ooo_core. Drives the four-phase decode handshake and checks
  every retirement against the reference model in program order.
  Needs a simulator with immediate assertions enabled.
*/
`timescale 1ns/1ps

module tb_ooo_core
  import ooo_pkg::*;
;

  localparam int CLK_NS       = 10;
  localparam int RESET_CYCLES = 8;
  localparam int TOTAL_INSTR  = 55;

  logic       clk;
  logic       i_reset;
  logic       i_dec_req;
  dec_instr_t i_dec_instr;
  logic       o_dec_ack;
  retire_t    o_retire;

  int n_checks  = 0;
  int n_errors  = 0;
  int hs_errors = 0;
  int n_sent    = 0;
  int n_retired = 0;
  int n_tests   = 0;
  logic prev_req = 1'b0;
  logic prev_ack = 1'b0;

  `include "tb_ooo_model.svh"

  ooo_core ooo_core_i (
    .clk, .i_reset, .i_dec_req, .i_dec_instr, .o_dec_ack, .o_retire
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // Bound of 200 cycles per instruction
  initial begin
    #(CLK_NS * (RESET_CYCLES + 200 * TOTAL_INSTR));
    $display("Timeout: the run did not finish in time, %0d of %0d retired", n_retired, n_sent);
    $display("Simulation FAILED");
    $finish;
  end

  // ==========================================================
  // Monitors sampled at the falling edge
  // ==========================================================
  always @(negedge clk) begin
    retire_t exp;
    if (!i_reset && o_retire.valid) begin
      n_retired++;
      n_checks++;
      assert (exp_q.size() != 0) else begin
        $display("Unexpected retirement of x%0d at %0t ns", o_retire.rd, $time);
        n_errors++;
      end
      if (exp_q.size() != 0) begin
        exp = exp_q.pop_front();
        n_checks++;
        assert (o_retire.rd == exp.rd && o_retire.value == exp.value) else begin
          $display("Mismatch at %0t ns: retired x%0d = %h, expected x%0d = %h",
                   $time, o_retire.rd, o_retire.value, exp.rd, exp.value);
          n_errors++;
        end
      end
    end
  end

  // Four-phase rules on req and ack
  always @(negedge clk) begin
    if (!i_reset) begin
      if (o_dec_ack && !prev_ack) begin
        n_checks++;
        assert (prev_req && i_dec_req) else begin
          $display("Handshake violation at %0t ns: ack rose while req was low", $time);
          n_errors++;
          hs_errors++;
        end
      end
      if (!o_dec_ack && prev_ack) begin
        n_checks++;
        assert (!prev_req) else begin
          $display("Handshake violation at %0t ns: ack fell before req fell", $time);
          n_errors++;
          hs_errors++;
        end
      end
    end
    prev_req = i_dec_req;
    prev_ack = o_dec_ack;
  end

  // ==========================================================
  // Stimulus helpers
  // ==========================================================
  task automatic send_instr(input dec_instr_t ins);
    model_dispatch(ins);
    n_sent++;
    @(posedge clk);
    i_dec_req   <= 1'b1;
    i_dec_instr <= ins;
    do begin
      @(negedge clk);
    end while (!o_dec_ack);
    @(posedge clk);
    i_dec_req <= 1'b0;
    do begin
      @(negedge clk);
    end while (o_dec_ack);
  endtask

  // Extra cycles after the queue empties catch stray retirements
  task automatic drain_retires();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (20) @(negedge clk);
  endtask

  task automatic report_test(input string name, input int errs);
    n_tests++;
    if (errs == 0) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errs);
    end
  endtask

  initial begin
    int errs;
    void'($urandom(32'hf478));
    i_reset     = 1'b1;
    i_dec_req   = 1'b0;
    i_dec_instr = '0;
    clear_model();
    repeat (RESET_CYCLES) @(posedge clk);
    i_reset <= 1'b0;

    errs = n_errors;
    @(negedge clk);
    n_checks++;
    assert (!o_dec_ack && !o_retire.valid) else begin
      $display("Mismatch at %0t ns: ack or retire valid high after reset", $time);
      n_errors++;
    end
    report_test("reset state", n_errors - errs);

    errs = n_errors;
    send_instr(addi_instr(1, 0, 32'd5));
    send_instr(addi_instr(2, 0, 32'h1234));
    send_instr(addi_instr(3, 0, 32'hffff_fff0));
    send_instr(addi_instr(4, 0, 32'd7));
    send_instr(addi_instr(5, 0, 32'd3));
    drain_retires();
    report_test("immediate loads", n_errors - errs);

    // RAW chains that end by rewriting x1
    errs = n_errors;
    send_instr(add_instr(6, 1, 2));
    send_instr(mul_instr(7, 6, 4));
    send_instr(add_instr(8, 7, 7));
    send_instr(mul_instr(9, 8, 3));
    send_instr(mul_instr(10, 9, 9));
    send_instr(add_instr(1, 10, 1));
    drain_retires();
    report_test("dependent chains", n_errors - errs);

    errs = n_errors;
    send_instr(mul_instr(11, 2, 2));
    send_instr(addi_instr(12, 0, 32'd100));
    send_instr(add_instr(13, 4, 5));
    send_instr(addi_instr(14, 12, 32'd9));
    drain_retires();
    report_test("out-of-order completion", n_errors - errs);

    errs = n_errors;
    for (int i = 0; i < 40; i++) begin
      send_instr(random_instr());
    end
    drain_retires();
    n_checks++;
    assert (n_retired == n_sent) else begin
      $display("Mismatch at %0t ns: %0d retired, %0d dispatched", $time, n_retired, n_sent);
      n_errors++;
    end
    report_test("random burst", n_errors - errs);

    report_test("handshake", hs_errors);
    $display("Tests: %0d, checks: %0d, errors: %0d, retired: %0d",
             n_tests, n_checks, n_errors, n_retired);
    if (n_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* ooo_core.f */
+incdir+test
hw/ooo_pkg.sv
hw/dispatch_stage.sv
hw/rename_regfile.sv
hw/exec_cluster.sv
hw/writeback_arbiter.sv
hw/reorder_buffer.sv
hw/ooo_core.sv
test/tb_ooo_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the ooo_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ooo_core -f ooo_core.f -o sim_ooo_core
./obj_dir/sim_ooo_core | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
grep -q "Simulation PASSED" sim.log
